//--- src.f
+incdir+sim
design/core_pkg.sv
design/stage_if.sv
design/fetch_unit.sv
design/decode_unit.sv
design/alu_unit.sv
design/reg_file.sv
design/riscv_core.sv
sim/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_core
FILELIST  ?= src.f

.PHONY: sim clean

# the run's own status is ignored, the log decides
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// in-order reference model of the retired instruction stream
logic [XLEN-1:0] model_regs [core_pkg::NUM_REGS];
logic [XLEN-1:0] model_pc;

task automatic clear_model();
    for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    model_pc = RESET_PC;
endtask

task automatic execute_model(
    input  core_pkg::inst_u                 w,
    output logic                            we,
    output logic [core_pkg::REG_ADDR_W-1:0] rd,
    output logic [XLEN-1:0]                 val
);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            is_reg;
    logic            is_imm;
    logic            ok;
    is_reg = w.r_view.opcode == core_pkg::OPC_OP;
    is_imm = w.i_view.opcode == core_pkg::OPC_OP_IMM;
    rd     = w.r_view.rd;
    a      = model_regs[w.r_view.rs1];
    b      = is_reg ? model_regs[w.r_view.rs2] :
             {{(XLEN-12){w.i_view.imm12[11]}}, w.i_view.imm12};
    // funct7 must be zero except 0100000 for sub
    ok = is_imm || (is_reg && (w.r_view.funct7 == 7'h00 ||
         (w.r_view.funct7 == 7'h20 && w.r_view.funct3 == 3'b000)));
    val = '0;
    case (w.r_view.funct3)
        3'b000:  val = (is_reg && w.r_view.funct7 == 7'h20) ? a - b : a + b;
        3'b010:  val = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
        3'b011:  val = {{(XLEN-1){1'b0}}, (a < b)};
        3'b100:  val = a ^ b;
        3'b110:  val = a | b;
        3'b111:  val = a & b;
        default: ok = 1'b0;
    endcase
    we = ok && rd != '0;
    if (we) begin
        model_regs[rd] = val;
    end
endtask

//**************************************************************************
// compare tasks
//**************************************************************************
task automatic check_data(input string name, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        stop_with_fail();
    end
endtask

task automatic check_inst(input string name, input core_pkg::inst_u got,
                          input core_pkg::inst_u exp);
    if (got !== exp) begin
        $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        stop_with_fail();
    end
endtask

task automatic check_addr(input string name, input logic [core_pkg::REG_ADDR_W-1:0] got,
                          input logic [core_pkg::REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
        $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        stop_with_fail();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        stop_with_fail();
    end
endtask

`endif

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int              XLEN           = 64;
    localparam logic [XLEN-1:0] RESET_PC       = '0;
    localparam int              N_INST         = 400;
    localparam int              RST_CYCLES     = 10;
    localparam int              TIMEOUT_CYCLES = RST_CYCLES + N_INST * 8 + 20;

    logic                            clk;
    logic                            rst_n_i;
    logic [XLEN-1:0]                 imem_addr_o;
    logic [core_pkg::INST_W-1:0]     imem_data_i;
    logic                            imem_valid_i;
    logic                            commit_o;
    logic [XLEN-1:0]                 pc_o;
    logic [core_pkg::INST_W-1:0]     inst_o;
    logic                            wb_we_o;
    logic [core_pkg::REG_ADDR_W-1:0] wb_addr_o;
    logic [XLEN-1:0]                 wb_data_o;

    core_pkg::inst_u prog [N_INST];
    int seed        = 6708;
    int retired     = 0;
    int edge_cnt    = 0;
    int accept_edge = 0;
    logic accepted  = 1'b0;
    logic [XLEN-1:0] fetch_pc;

    riscv_core #(.XLEN(XLEN), .RESET_PC(RESET_PC)) dut (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .imem_addr_o  ( imem_addr_o  ),
        .imem_data_i  ( imem_data_i  ),
        .imem_valid_i ( imem_valid_i ),
        .commit_o     ( commit_o     ),
        .pc_o         ( pc_o         ),
        .inst_o       ( inst_o       ),
        .wb_we_o      ( wb_we_o      ),
        .wb_addr_o    ( wb_addr_o    ),
        .wb_data_o    ( wb_data_o    )
    );

    task automatic stop_with_fail();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on error");
    endtask

    `include "core_model.svh"

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    // small register subset so hazards come often
    function automatic logic [core_pkg::REG_ADDR_W-1:0] pick_reg();
        return 5'(rand_below(6));
    endfunction

    //**************************************************************************
    // random program
    //**************************************************************************
    task automatic gen_program();
        core_pkg::inst_u w;
        logic [31:0]     r;
        int unsigned     kind;
        for (int i = 0; i < N_INST; i++) begin
            kind = rand_below(100);
            r    = $random(seed);
            w    = r;
            w.r_view.rd  = pick_reg();
            w.r_view.rs1 = pick_reg();
            w.r_view.rs2 = pick_reg();
            if (kind < 85 && rand_below(2) == 0) begin
                w.r_view.opcode = core_pkg::OPC_OP;
                w.r_view.funct7 = 7'h00;
                case (rand_below(7))
                    0: w.r_view.funct3 = 3'b000;
                    1: begin
                        w.r_view.funct3 = 3'b000;
                        w.r_view.funct7 = 7'h20;
                    end
                    2: w.r_view.funct3 = 3'b010;
                    3: w.r_view.funct3 = 3'b011;
                    4: w.r_view.funct3 = 3'b100;
                    5: w.r_view.funct3 = 3'b110;
                    default: w.r_view.funct3 = 3'b111;
                endcase
            end else if (kind < 85) begin
                // imm12 keeps its random bits so negative values appear
                w.i_view.opcode = core_pkg::OPC_OP_IMM;
                case (rand_below(6))
                    0: w.i_view.funct3 = 3'b000;
                    1: w.i_view.funct3 = 3'b010;
                    2: w.i_view.funct3 = 3'b011;
                    3: w.i_view.funct3 = 3'b100;
                    4: w.i_view.funct3 = 3'b110;
                    default: w.i_view.funct3 = 3'b111;
                endcase
            end else if (kind < 92) begin
                // shift encodings the core does not support
                w.r_view.opcode = (rand_below(2) == 0) ? core_pkg::OPC_OP : core_pkg::OPC_OP_IMM;
                w.r_view.funct3 = (rand_below(2) == 0) ? 3'b001 : 3'b101;
            end
            prog[i] = w;
        end
    endtask

    task automatic drive_fetch();
        int unsigned word_idx;
        word_idx = 32'(imem_addr_o >> 2);
        if (imem_addr_o < XLEN'(N_INST * 4) && rand_below(100) < 75) begin
            imem_valid_i = 1'b1;
            imem_data_i  = prog[word_idx];
        end else begin
            imem_valid_i = 1'b0;
            imem_data_i  = '0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset then fetch stimulus 1 ns after each rising edge
    initial begin
        rst_n_i      = 1'b0;
        imem_valid_i = 1'b0;
        imem_data_i  = '0;
        fetch_pc     = RESET_PC;
        gen_program();
        clear_model();
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        forever begin
            @(posedge clk);
            edge_cnt++;
            if (imem_valid_i) begin
                fetch_pc = fetch_pc + XLEN'(4);
                if (!accepted) begin
                    accepted    = 1'b1;
                    accept_edge = edge_cnt;
                end
            end
            #1;
            check_data("imem_addr_o", imem_addr_o, fetch_pc);
            drive_fetch();
        end
    end

    //**************************************************************************
    // retire checks
    //**************************************************************************
    initial begin : retire_monitor
        logic                            exp_we;
        logic [core_pkg::REG_ADDR_W-1:0] exp_rd;
        logic [XLEN-1:0]                 exp_val;
        logic                            first_seen;
        first_seen = 1'b0;
        while (retired < N_INST) begin
            @(negedge clk);
            if (rst_n_i && commit_o) begin
                if (!first_seen) begin
                    // accept edge plus two more edges
                    if (!accepted || edge_cnt - accept_edge != 2) begin
                        $display("first commit did not come 3 edges after the first fetch");
                        stop_with_fail();
                    end
                    first_seen = 1'b1;
                end
                check_data("pc_o", pc_o, model_pc);
                check_inst("inst_o", inst_o, prog[retired]);
                execute_model(prog[retired], exp_we, exp_rd, exp_val);
                check_flag("wb_we_o", wb_we_o, exp_we);
                if (exp_we) begin
                    check_addr("wb_addr_o", wb_addr_o, exp_rd);
                    check_data("wb_data_o", wb_data_o, exp_val);
                end
                model_pc = model_pc + XLEN'(4);
                retired++;
            end else if (rst_n_i) begin
                check_flag("wb_we_o", wb_we_o, 1'b0);
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: retirement stalled after %0d of %0d instructions",
                 retired, N_INST);
        stop_with_fail();
    end

endmodule

//--- design/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
    parameter int              XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    output logic [XLEN-1:0]                 imem_addr_o,
    input  logic [core_pkg::INST_W-1:0]     imem_data_i,
    input  logic                            imem_valid_i,
    output logic                            commit_o,
    output logic [XLEN-1:0]                 pc_o,
    output logic [core_pkg::INST_W-1:0]     inst_o,
    output logic                            wb_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]                 wb_data_o
);

    logic                            id_valid;
    logic [XLEN-1:0]                 id_pc;
    core_pkg::inst_u                 id_inst;
    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]                 rs1_data;
    logic [XLEN-1:0]                 rs2_data;
    logic [XLEN-1:0]                 ex_result;
    logic                            wb_we;
    logic [core_pkg::REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]                 wb_data;

    stage_if #(.XLEN(XLEN)) ex_bus ();

    assign wb_we_o   = wb_we;
    assign wb_addr_o = wb_addr;
    assign wb_data_o = wb_data;

    fetch_unit #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_fetch (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .imem_valid_i ( imem_valid_i ),
        .imem_data_i  ( imem_data_i  ),
        .imem_addr_o  ( imem_addr_o  ),
        .id_valid_o   ( id_valid     ),
        .id_pc_o      ( id_pc        ),
        .id_inst_o    ( id_inst      )
    );

    decode_unit #(.XLEN(XLEN)) u_decode (
        .clk         ( clk       ),
        .rst_n_i     ( rst_n_i   ),
        .id_valid_i  ( id_valid  ),
        .id_pc_i     ( id_pc     ),
        .id_inst_i   ( id_inst   ),
        .rs1_addr_o  ( rs1_addr  ),
        .rs2_addr_o  ( rs2_addr  ),
        .rs1_data_i  ( rs1_data  ),
        .rs2_data_i  ( rs2_data  ),
        .ex_result_i ( ex_result ),
        .wb_we_i     ( wb_we     ),
        .wb_addr_i   ( wb_addr   ),
        .wb_data_i   ( wb_data   ),
        .ex_bus      ( ex_bus    )
    );

    alu_unit #(.XLEN(XLEN)) u_alu (
        .clk         ( clk       ),
        .rst_n_i     ( rst_n_i   ),
        .ex_bus      ( ex_bus    ),
        .ex_result_o ( ex_result ),
        .commit_o    ( commit_o  ),
        .pc_o        ( pc_o      ),
        .inst_o      ( inst_o    ),
        .wb_we_o     ( wb_we     ),
        .wb_addr_o   ( wb_addr   ),
        .wb_data_o   ( wb_data   )
    );

    reg_file #(.XLEN(XLEN)) u_regs (
        .clk      ( clk      ),
        .rst_n_i  ( rst_n_i  ),
        .raddr1_i ( rs1_addr ),
        .raddr2_i ( rs2_addr ),
        .rdata1_o ( rs1_data ),
        .rdata2_o ( rs2_data ),
        .wen_i    ( wb_we    ),
        .waddr_i  ( wb_addr  ),
        .wdata_i  ( wb_data  )
    );

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int XLEN = 64
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]                 rdata1_o,
    output logic [XLEN-1:0]                 rdata2_o,
    input  logic                            wen_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]                 wdata_i
);

    logic [XLEN-1:0] regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int XLEN = 64
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    stage_if.execute                        ex_bus,
    output logic [XLEN-1:0]                 ex_result_o,
    output logic                            commit_o,
    output logic [XLEN-1:0]                 pc_o,
    output logic [core_pkg::INST_W-1:0]     inst_o,
    output logic                            wb_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]                 wb_data_o
);

    logic [XLEN-1:0] result;
    logic            lt_s;
    logic            lt_u;

    assign lt_s = $signed(ex_bus.op1) < $signed(ex_bus.op2);
    assign lt_u = ex_bus.op1 < ex_bus.op2;

    always_comb begin
        case (ex_bus.alu_sel)
            core_pkg::ALU_ADD:  result = ex_bus.op1 + ex_bus.op2;
            core_pkg::ALU_SUB:  result = ex_bus.op1 - ex_bus.op2;
            core_pkg::ALU_AND:  result = ex_bus.op1 & ex_bus.op2;
            core_pkg::ALU_OR:   result = ex_bus.op1 | ex_bus.op2;
            core_pkg::ALU_XOR:  result = ex_bus.op1 ^ ex_bus.op2;
            core_pkg::ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            core_pkg::ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            default:            result = '0;
        endcase
    end

    // back to decode for forwarding
    assign ex_result_o = result;

    //**************************************************************************
    // ex/wb register, feeds writeback and retire
    //**************************************************************************
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end else begin
            commit_o <= ex_bus.valid;
            wb_we_o  <= ex_bus.valid && ex_bus.we;
        end
    end

    always_ff @(posedge clk) begin
        pc_o      <= ex_bus.pc;
        inst_o    <= ex_bus.inst;
        wb_addr_o <= ex_bus.rd;
        wb_data_o <= result;
    end

endmodule

//--- design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit #(
    parameter int XLEN = 64
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            id_valid_i,
    input  logic [XLEN-1:0]                 id_pc_i,
    input  core_pkg::inst_u                 id_inst_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]                 rs1_data_i,
    input  logic [XLEN-1:0]                 rs2_data_i,
    input  logic [XLEN-1:0]                 ex_result_i,
    input  logic                            wb_we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]                 wb_data_i,
    stage_if.decode                         ex_bus
);

    logic                            is_op;
    logic                            is_op_imm;
    logic [2:0]                      funct3;
    logic                            funct_ok;
    logic [core_pkg::ALU_SEL_W-1:0]  alu_sel;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]                 imm;
    logic [XLEN-1:0]                 rs1_val;
    logic [XLEN-1:0]                 rs2_val;
    logic                            we;
    logic                            ex_fwd_en;

    assign is_op     = id_inst_i.r_view.opcode == core_pkg::OPC_OP;
    assign is_op_imm = id_inst_i.i_view.opcode == core_pkg::OPC_OP_IMM;

    assign funct3     = id_inst_i.r_view.funct3;
    assign rd         = id_inst_i.r_view.rd;
    assign rs1_addr_o = id_inst_i.r_view.rs1;
    // immediate ops have no second source
    assign rs2_addr_o = is_op ? id_inst_i.r_view.rs2 : '0;

    assign imm = {{(XLEN-12){id_inst_i.i_view.imm12[11]}}, id_inst_i.i_view.imm12};

    always_comb begin
        alu_sel  = core_pkg::ALU_ADD;
        funct_ok = 1'b1;
        case (funct3)
            3'b000: alu_sel = (is_op && id_inst_i.r_view.funct7[5]) ?
                              core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b010: alu_sel = core_pkg::ALU_SLT;
            3'b011: alu_sel = core_pkg::ALU_SLTU;
            3'b100: alu_sel = core_pkg::ALU_XOR;
            3'b110: alu_sel = core_pkg::ALU_OR;
            3'b111: alu_sel = core_pkg::ALU_AND;
            // shifts are not implemented
            default: funct_ok = 1'b0;
        endcase
        // funct7 is 0000000 or 0100000 for sub only
        if (is_op && id_inst_i.r_view.funct7 != 7'b0000000) begin
            if (id_inst_i.r_view.funct7 != 7'b0100000 || funct3 != 3'b000) begin
                funct_ok = 1'b0;
            end
        end
    end

    assign we = (is_op || is_op_imm) && funct_ok && rd != '0;

    //**************************************************************************
    // forwarding priority is ex result then wb then register file
    //**************************************************************************
    assign ex_fwd_en = ex_bus.valid && ex_bus.we;

    function automatic logic [XLEN-1:0] fwd(
        input logic [core_pkg::REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]                 rf_data
    );
        if (addr == '0) begin
            return '0;
        end else if (ex_fwd_en && ex_bus.rd == addr) begin
            return ex_result_i;
        end else if (wb_we_i && wb_addr_i == addr) begin
            return wb_data_i;
        end
        return rf_data;
    endfunction

    assign rs1_val = fwd(rs1_addr_o, rs1_data_i);
    assign rs2_val = fwd(rs2_addr_o, rs2_data_i);

    // id/ex register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_bus.valid <= 1'b0;
            ex_bus.we    <= 1'b0;
        end else begin
            ex_bus.valid <= id_valid_i;
            ex_bus.we    <= id_valid_i && we;
        end
    end

    always_ff @(posedge clk) begin
        ex_bus.pc      <= id_pc_i;
        ex_bus.inst    <= id_inst_i;
        ex_bus.alu_sel <= alu_sel;
        ex_bus.op1     <= rs1_val;
        ex_bus.op2     <= is_op_imm ? imm : rs2_val;
        ex_bus.rd      <= rd;
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int              XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        imem_valid_i,
    input  logic [core_pkg::INST_W-1:0] imem_data_i,
    output logic [XLEN-1:0]             imem_addr_o,
    output logic                        id_valid_o,
    output logic [XLEN-1:0]             id_pc_o,
    output core_pkg::inst_u             id_inst_o
);

    logic [XLEN-1:0] pc;

    assign imem_addr_o = pc;

    // pc holds while the word is missing
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc <= RESET_PC;
        end else if (imem_valid_i) begin
            pc <= pc + XLEN'(4);
        end
    end

    //**************************************************************************
    // if/id register
    //**************************************************************************
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else begin
            // bubble when no word accepted
            id_valid_o <= imem_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_valid_i) begin
            id_pc_o   <= pc;
            id_inst_o <= imem_data_i;
        end
    end

endmodule

//--- design/stage_if.sv
`timescale 1ns/1ps

// id/ex pipeline register bundle
interface stage_if #(
    parameter int XLEN = 64
);

    logic                                  valid;
    logic [XLEN-1:0]                       pc;
    core_pkg::inst_u                       inst;
    logic [core_pkg::ALU_SEL_W-1:0]        alu_sel;
    logic [XLEN-1:0]                       op1;
    logic [XLEN-1:0]                       op2;
    logic [core_pkg::REG_ADDR_W-1:0]       rd;
    logic                                  we;

    modport decode (
        output valid, pc, inst, alu_sel, op1, op2, rd, we
    );

    modport execute (
        input  valid, pc, inst, alu_sel, op1, op2, rd, we
    );

endinterface

//--- design/core_pkg.sv
package core_pkg;

    //**************************************************************************
    // widths
    //**************************************************************************
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_SEL_W  = 4;

    //**************************************************************************
    // alu operation select
    //**************************************************************************
    localparam logic [ALU_SEL_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_SEL_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_SEL_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_SEL_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_SEL_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_SEL_W-1:0] ALU_SLT  = 4'd5;
    localparam logic [ALU_SEL_W-1:0] ALU_SLTU = 4'd6;

    // major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    //**************************************************************************
    // instruction word, register and immediate formats
    //**************************************************************************
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
    } inst_u;

endpackage
